// File: hdl/fm_pkg.sv
// shared types and register constants for the FM register front end
package fm_pkg;

    typedef logic [7:0] byte_t;   // host data byte or register address
    typedef logic [9:0] fnum_t;   // frequency number
    typedef logic [2:0] block_t;  // octave, also used for feedback
    typedef logic [3:0] nib_t;    // rates, multiplier, sustain level
    typedef logic [5:0] tl_t;     // total level
    typedef logic [1:0] group_t;  // slot group 0..2
    typedef logic [2:0] sub_t;    // subslot 0..5

    localparam int SLOTS = 18;

    // timer registers
    localparam byte_t REG_CLKA  = 8'h02;
    localparam byte_t REG_CLKB  = 8'h03;
    localparam byte_t REG_TIMER = 8'h04;

    // operator register bases, taken from address bits 7:5
    localparam logic [2:0] OP_MULT   = 3'b001;  // 20
    localparam logic [2:0] OP_KSL_TL = 3'b010;  // 40
    localparam logic [2:0] OP_AR_DR  = 3'b011;  // 60
    localparam logic [2:0] OP_SL_RR  = 3'b100;  // 80

    // channel register bases, taken from address bits 7:4
    localparam logic [3:0] CH_FNUM_LO = 4'hA;
    localparam logic [3:0] CH_FNUM_HI = 4'hB;
    localparam logic [3:0] CH_FBCON   = 4'hC;

    // decoder FSM
    typedef enum logic {
        ST_IDLE,
        ST_PENDING
    } mmr_state_t;

endpackage

// File: hdl/fm_ifs.sv
// interfaces between the register decoder and the blocks it steers
`timescale 1ns/100ps

interface fm_upd_if import fm_pkg::*; ();
    group_t sel_group;   // target slot
    sub_t   sel_sub;
    byte_t  data;
    byte_t  latch_fnum;  // low fnum byte from A0
    logic   up_mult;
    logic   up_ksl_tl;
    logic   up_ar_dr;
    logic   up_sl_rr;
    logic   up_fnum;
    logic   up_fbcon;
    logic   done_op;     // from the operator file
    logic   done_ch;     // from the channel file
    logic   done;

    assign done = done_op | done_ch;

    modport mmr (
        output sel_group, sel_sub, data, latch_fnum,
        output up_mult, up_ksl_tl, up_ar_dr, up_sl_rr, up_fnum, up_fbcon,
        input  done
    );

    modport regs (
        input  sel_group, sel_sub, data, latch_fnum,
        input  up_mult, up_ksl_tl, up_ar_dr, up_sl_rr, up_fnum, up_fbcon,
        output done_op, done_ch
    );
endinterface

interface fm_timer_if import fm_pkg::*; ();
    byte_t value_a;
    byte_t value_b;
    logic  load_a;
    logic  load_b;
    logic  flagen_a;
    logic  flagen_b;
    logic  clr_flags;  // single cycle

    modport mmr (output value_a, value_b, load_a, load_b, flagen_a, flagen_b, clr_flags);
    modport timers (input value_a, value_b, load_a, load_b, flagen_a, flagen_b, clr_flags);
endinterface

// File: hdl/fm_slot_seq.sv
// slot sequencer that divides the clock enable and walks the 18 operator slots
`timescale 1ns/100ps

module fm_slot_seq import fm_pkg::*; #(
    parameter int CEN_DIV = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   cen,
    output logic   cenop,
    output logic   zero,
    output group_t group,
    output sub_t   sub
);
    localparam int DW = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam logic [DW-1:0] DIV_LAST = DW'(CEN_DIV - 1);

    logic [DW-1:0] div_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            cenop   <= 1'b0;
        end else begin
            cenop <= cen && (div_cnt == DIV_LAST);  // one clock wide
            if (cen) begin
                div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
            end
        end
    end

    // group 0 subslots 0..5, then group 1, then group 2
    always_ff @(posedge clk) begin
        if (rst) begin
            group <= '0;
            sub   <= '0;
        end else if (cenop) begin
            if (sub == 3'd5) begin
                sub   <= '0;
                group <= (group == 2'd2) ? 2'd0 : group + 2'd1;
            end else begin
                sub <= sub + 3'd1;
            end
        end
    end

    assign zero = (group == 2'd0) && (sub == 3'd0);

endmodule

// File: hdl/fm_mmr.sv
// host register decoder that turns address and data writes into timer control and slot updates
`timescale 1ns/100ps

module fm_mmr import fm_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    wr_valid,
    input  logic    addr,
    input  byte_t   din,
    output logic    wr_ready,
    fm_upd_if.mmr   upd,
    fm_timer_if.mmr tmr
);
    byte_t      selreg;     // selected register
    mmr_state_t state;
    logic       xfer;
    logic       op_addr;
    logic       ch_upd;
    logic [3:0] ch_num;
    group_t     ch_group;
    logic [3:0] ch_base;
    logic [3:0] ch_off;

    assign wr_ready = (state == ST_IDLE);
    assign xfer     = wr_valid && wr_ready;

    // 20..9F with a valid group and subslot
    assign op_addr = (selreg >= 8'h20) && (selreg < 8'hA0) &&
                     (selreg[2:0] <= 3'd5) && (selreg[4:3] != 2'b11);

    assign ch_num = selreg[3:0];
    assign ch_upd = (ch_num <= 4'd8) &&
                    (selreg[7:4] == CH_FNUM_HI || selreg[7:4] == CH_FBCON);

    // channel n lives on slot (n/3, n mod 3)
    always_comb begin
        if (ch_num < 4'd3) begin
            ch_group = 2'd0;
            ch_base  = 4'd0;
        end else if (ch_num < 4'd6) begin
            ch_group = 2'd1;
            ch_base  = 4'd3;
        end else begin
            ch_group = 2'd2;
            ch_base  = 4'd6;
        end
    end

    assign ch_off = ch_num - ch_base;

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= ST_IDLE;
            selreg         <= '0;
            upd.sel_group  <= '0;
            upd.sel_sub    <= '0;
            upd.data       <= '0;
            upd.latch_fnum <= '0;
            upd.up_mult    <= 1'b0;
            upd.up_ksl_tl  <= 1'b0;
            upd.up_ar_dr   <= 1'b0;
            upd.up_sl_rr   <= 1'b0;
            upd.up_fnum    <= 1'b0;
            upd.up_fbcon   <= 1'b0;
            tmr.value_a    <= '0;
            tmr.value_b    <= '0;
            tmr.load_a     <= 1'b0;
            tmr.load_b     <= 1'b0;
            tmr.flagen_a   <= 1'b1;
            tmr.flagen_b   <= 1'b1;
            tmr.clr_flags  <= 1'b0;
        end else begin
            tmr.clr_flags <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (xfer && !addr) begin
                        selreg <= din;
                    end else if (xfer) begin
                        case (selreg)
                            REG_CLKA: tmr.value_a <= din;
                            REG_CLKB: tmr.value_b <= din;
                            REG_TIMER: begin
                                if (din[7]) begin
                                    tmr.clr_flags <= 1'b1;  // IRQ reset, rest ignored
                                end else begin
                                    tmr.flagen_a <= ~din[6];
                                    tmr.flagen_b <= ~din[5];
                                    tmr.load_b   <= din[1];
                                    tmr.load_a   <= din[0];
                                end
                            end
                            default: ;
                        endcase
                        if (op_addr) begin
                            upd.sel_group <= selreg[4:3];
                            upd.sel_sub   <= selreg[2:0];
                            upd.data      <= din;
                            upd.up_mult   <= (selreg[7:5] == OP_MULT);
                            upd.up_ksl_tl <= (selreg[7:5] == OP_KSL_TL);
                            upd.up_ar_dr  <= (selreg[7:5] == OP_AR_DR);
                            upd.up_sl_rr  <= (selreg[7:5] == OP_SL_RR);
                            state         <= ST_PENDING;
                        end
                        if (ch_num <= 4'd8 && selreg[7:4] == CH_FNUM_LO) begin
                            upd.latch_fnum <= din;  // held until B0 arrives
                        end
                        if (ch_upd) begin
                            upd.sel_group <= ch_group;
                            upd.sel_sub   <= ch_off[2:0];
                            upd.data      <= din;
                            upd.up_fnum   <= (selreg[7:4] == CH_FNUM_HI);
                            upd.up_fbcon  <= (selreg[7:4] == CH_FBCON);
                            state         <= ST_PENDING;
                        end
                    end
                end
                ST_PENDING: begin
                    if (upd.done) begin  // target slot has taken it
                        upd.up_mult   <= 1'b0;
                        upd.up_ksl_tl <= 1'b0;
                        upd.up_ar_dr  <= 1'b0;
                        upd.up_sl_rr  <= 1'b0;
                        upd.up_fnum   <= 1'b0;
                        upd.up_fbcon  <= 1'b0;
                        state         <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/fm_timers.sv
// timer A and timer B counters with overflow flags and interrupt
`timescale 1ns/100ps

module fm_timers import fm_pkg::*; #(
    parameter int TIMER_B_DIV = 16
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cenop,
    input  logic          zero,
    fm_timer_if.timers    tmr,
    output logic          flag_a,
    output logic          flag_b,
    output logic          irq
);
    localparam int PW = (TIMER_B_DIV > 1) ? $clog2(TIMER_B_DIV) : 1;
    localparam logic [PW-1:0] PRE_LAST = PW'(TIMER_B_DIV - 1);

    byte_t         cnt_a;
    byte_t         cnt_b;
    logic [PW-1:0] pre_b;
    logic          tick;     // once per slot cycle
    logic          tick_b;
    logic          run_a;    // set on the first slot cycle after the load
    logic          ovf_a;
    logic          ovf_b;

    assign tick   = cenop && zero;
    assign tick_b = tick && (pre_b == PRE_LAST);
    assign ovf_a  = tmr.load_a && run_a && tick && (cnt_a == 8'hFF);
    assign ovf_b  = tmr.load_b && tick_b && (cnt_b == 8'hFF);

    always_ff @(posedge clk) begin
        if (rst || !tmr.load_a) begin
            run_a <= 1'b0;
        end else if (tick) begin
            run_a <= 1'b1;
        end
    end

    // a stopped counter tracks its start value
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= '0;
        end else if (!tmr.load_a || !run_a || ovf_a) begin
            cnt_a <= tmr.value_a;
        end else if (tick) begin
            cnt_a <= cnt_a + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !tmr.load_b) begin
            pre_b <= '0;
        end else if (tick) begin
            pre_b <= tick_b ? '0 : pre_b + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_b <= '0;
        end else if (!tmr.load_b || ovf_b) begin
            cnt_b <= tmr.value_b;
        end else if (tick_b) begin
            cnt_b <= cnt_b + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || tmr.clr_flags) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ovf_a && tmr.flagen_a) flag_a <= 1'b1;
            if (ovf_b && tmr.flagen_b) flag_b <= 1'b1;
        end
    end

    assign irq = flag_a | flag_b;

endmodule

// File: hdl/fm_op_regs.sv
// per-operator parameter storage, written on the target slot and read out per slot
`timescale 1ns/100ps

module fm_op_regs import fm_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   cenop,
    input  group_t group,
    input  sub_t   sub,
    fm_upd_if.regs upd,
    output nib_t   mul,
    output nib_t   arate,
    output nib_t   drate,
    output nib_t   rrate,
    output nib_t   sl,
    output tl_t    tl,
    output logic   en_sus,
    output logic   ks
);
    byte_t      reg_mult  [SLOTS];  // 20: en_sus, ks, mul
    byte_t      reg_tl    [SLOTS];  // 40: tl
    byte_t      reg_ar_dr [SLOTS];  // 60
    byte_t      reg_sl_rr [SLOTS];  // 80
    logic [4:0] slot;
    logic       hit;

    assign slot = 5'(group) * 5'd6 + 5'(sub);
    assign hit  = cenop && (group == upd.sel_group) && (sub == upd.sel_sub) &&
                  (upd.up_mult || upd.up_ksl_tl || upd.up_ar_dr || upd.up_sl_rr);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SLOTS; i++) begin
                reg_mult[i]  <= '0;
                reg_tl[i]    <= '0;
                reg_ar_dr[i] <= '0;
                reg_sl_rr[i] <= '0;
            end
            upd.done_op <= 1'b0;
        end else begin
            upd.done_op <= hit;
            if (hit && upd.up_mult)   reg_mult[slot]  <= upd.data;
            if (hit && upd.up_ksl_tl) reg_tl[slot]    <= upd.data;
            if (hit && upd.up_ar_dr)  reg_ar_dr[slot] <= upd.data;
            if (hit && upd.up_sl_rr)  reg_sl_rr[slot] <= upd.data;
        end
    end

    // fields of the slot on show, one clock behind the slot change
    always_ff @(posedge clk) begin
        if (rst) begin
            {en_sus, ks, mul} <= '0;
            tl                <= '0;
            {arate, drate}    <= '0;
            {sl, rrate}       <= '0;
        end else begin
            {en_sus, ks, mul} <= reg_mult[slot][5:0];
            tl                <= reg_tl[slot][5:0];
            {arate, drate}    <= reg_ar_dr[slot];
            {sl, rrate}       <= reg_sl_rr[slot];
        end
    end

endmodule

// File: hdl/fm_ch_regs.sv
// per-channel frequency, key and connection storage with per-slot read-out
`timescale 1ns/100ps

module fm_ch_regs import fm_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   cenop,
    input  group_t group,
    input  sub_t   sub,
    fm_upd_if.regs upd,
    output fnum_t  fnum,
    output block_t block,
    output logic   keyon,
    output logic   con,
    output block_t fb
);
    fnum_t      fnum_mem  [9];
    block_t     block_mem [9];
    logic       keyon_mem [9];
    block_t     fb_mem    [9];
    logic       con_mem   [9];
    sub_t       sub_m3;      // both operators of a channel share it
    logic [3:0] ch;
    logic       hit;

    assign sub_m3 = (sub >= 3'd3) ? sub - 3'd3 : sub;
    assign ch     = 4'(group) * 4'd3 + 4'(sub_m3);
    assign hit    = cenop && (group == upd.sel_group) && (sub == upd.sel_sub) &&
                    (upd.up_fnum || upd.up_fbcon);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 9; i++) begin
                fnum_mem[i]  <= '0;
                block_mem[i] <= '0;
                keyon_mem[i] <= 1'b0;
                fb_mem[i]    <= '0;
                con_mem[i]   <= 1'b0;
            end
            upd.done_ch <= 1'b0;
        end else begin
            upd.done_ch <= hit;
            if (hit && upd.up_fnum) begin
                fnum_mem[ch]  <= {upd.data[1:0], upd.latch_fnum};
                block_mem[ch] <= upd.data[4:2];
                keyon_mem[ch] <= upd.data[5];
            end
            if (hit && upd.up_fbcon) begin
                fb_mem[ch]  <= upd.data[3:1];
                con_mem[ch] <= upd.data[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fnum  <= '0;
            block <= '0;
            keyon <= 1'b0;
            fb    <= '0;
            con   <= 1'b0;
        end else begin
            fnum  <= fnum_mem[ch];
            block <= block_mem[ch];
            keyon <= keyon_mem[ch];
            fb    <= fb_mem[ch];
            con   <= con_mem[ch];
        end
    end

endmodule

// File: hdl/fm_regs_top.sv
// FM register front end top level joining decoder, slot sequencer, timers and register files
`timescale 1ns/100ps

module fm_regs_top import fm_pkg::*; #(
    parameter int CEN_DIV     = 4,
    parameter int TIMER_B_DIV = 16
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   cen,
    input  logic   wr_valid,
    output logic   wr_ready,
    input  logic   addr,      // low selects, high writes data
    input  byte_t  din,
    output logic   zero,
    output group_t group,
    output sub_t   sub,
    output nib_t   mul,
    output nib_t   arate,
    output nib_t   drate,
    output nib_t   rrate,
    output nib_t   sl,
    output tl_t    tl,
    output logic   en_sus,
    output logic   ks,
    output fnum_t  fnum,
    output block_t block,
    output logic   keyon,
    output logic   con,
    output block_t fb,
    output logic   flag_a,
    output logic   flag_b,
    output logic   irq
);
    logic cenop;

    fm_upd_if   upd_if ();
    fm_timer_if tmr_if ();

    fm_slot_seq #(.CEN_DIV(CEN_DIV)) u_seq (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .cenop (cenop),
        .zero  (zero),
        .group (group),
        .sub   (sub)
    );

    fm_mmr u_mmr (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (wr_valid),
        .addr     (addr),
        .din      (din),
        .wr_ready (wr_ready),
        .upd      (upd_if.mmr),
        .tmr      (tmr_if.mmr)
    );

    fm_timers #(.TIMER_B_DIV(TIMER_B_DIV)) u_timers (
        .clk    (clk),
        .rst    (rst),
        .cenop  (cenop),
        .zero   (zero),
        .tmr    (tmr_if.timers),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .irq    (irq)
    );

    fm_op_regs u_op (
        .clk    (clk),
        .rst    (rst),
        .cenop  (cenop),
        .group  (group),
        .sub    (sub),
        .upd    (upd_if.regs),
        .mul    (mul),
        .arate  (arate),
        .drate  (drate),
        .rrate  (rrate),
        .sl     (sl),
        .tl     (tl),
        .en_sus (en_sus),
        .ks     (ks)
    );

    fm_ch_regs u_ch (
        .clk   (clk),
        .rst   (rst),
        .cenop (cenop),
        .group (group),
        .sub   (sub),
        .upd   (upd_if.regs),
        .fnum  (fnum),
        .block (block),
        .keyon (keyon),
        .con   (con),
        .fb    (fb)
    );

endmodule

// File: bench/fm_properties.sv
// handshake and slot order assertions for the FM register front end
`timescale 1ns/100ps

module fm_properties import fm_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   cenop,
    input logic   zero,
    input group_t group,
    input logic   wr_valid,
    input logic   wr_ready,
    input logic   addr,
    input byte_t  din
);
    int unsigned ops_since_zero;  // operator ticks since the last slot 0 tick

    always_ff @(posedge clk) begin
        if (rst) begin
            ops_since_zero <= 0;
        end else if (cenop) begin
            ops_since_zero <= zero ? 1 : ops_since_zero + 1;
        end
    end

    // a stalled write holds its address and data
    assert property (@(posedge clk) disable iff (rst)
        wr_valid && !wr_ready |=> $stable(addr) && $stable(din))
        else $error("addr or din changed while a write was stalled");

    assert property (@(posedge clk) disable iff (rst)
        cenop && zero && ops_since_zero != 0 |-> ops_since_zero == SLOTS)
        else $error("slot 0 did not recur after 18 operator ticks");

    assert property (@(posedge clk) disable iff (rst)
        cenop && !zero |-> ops_since_zero < SLOTS)
        else $error("more than 18 operator ticks without slot 0");

    assert property (@(posedge clk) disable iff (rst) group != 2'd3)
        else $error("slot group reached 3");

endmodule

bind fm_regs_top fm_properties props0 (
    .clk      (clk),
    .rst      (rst),
    .cenop    (cenop),
    .zero     (zero),
    .group    (group),
    .wr_valid (wr_valid),
    .wr_ready (wr_ready),
    .addr     (addr),
    .din      (din)
);

// File: bench/fm_tb.sv
// testbench for the FM register front end, stepping through the golden command file
`timescale 1ns/100ps

module fm_tb import fm_pkg::*; ();
    localparam int CEN_DIV   = 4;                // DUT default
    localparam int CLK_NS    = 4;
    localparam int SLOT_CLKS = SLOTS * CEN_DIV;  // clocks per full slot cycle
    localparam int MAX_LINES = 64;

    logic   clk = 1'b0;
    logic   rst;
    logic   cen;
    logic   wr_valid;
    logic   wr_ready;
    logic   addr;
    byte_t  din;
    logic   zero;
    group_t group;
    sub_t   sub;
    nib_t   mul;
    nib_t   arate;
    nib_t   drate;
    nib_t   rrate;
    nib_t   sl;
    tl_t    tl;
    logic   en_sus;
    logic   ks;
    fnum_t  fnum;
    block_t block;
    logic   keyon;
    logic   con;
    block_t fb;
    logic   flag_a;
    logic   flag_b;
    logic   irq;

    logic [79:0] golden [MAX_LINES];
    int          n_lines = 0;
    int          errors = 0;
    time         last_write = 0;  // time of the last accepted host write

    fm_regs_top dut0 (.*);

    always #(CLK_NS / 2) clk = ~clk;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic wait_ready();
        while (!wr_ready) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one host transfer, then ready must match what the write type implies
    task automatic host_write(input logic a, input byte_t d, input logic busy);
        wr_valid = 1'b1;
        addr     = a;
        din      = d;
        wait_ready();
        @(posedge clk);  // transfer edge
        #1;
        wr_valid   = 1'b0;
        last_write = $time;
        compare_field("wr_ready", wr_ready, !busy);
    endtask

    // params of a slot are valid one clock after the slot shows up
    task automatic find_slot(input group_t g, input sub_t s);
        while (group == g && sub == s) begin
            @(posedge clk);
            #1;
        end
        while (!(group == g && sub == s)) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_outputs(input logic [79:0] w);
        compare_field("mul", mul, w[67:64]);
        compare_field("arate", arate, w[63:60]);
        compare_field("drate", drate, w[59:56]);
        compare_field("rrate", rrate, w[55:52]);
        compare_field("sl", sl, w[51:48]);
        compare_field("tl", tl, w[47:40]);
        compare_field("en_sus", en_sus, w[39:36]);
        compare_field("ks", ks, w[35:32]);
        compare_field("fnum", fnum, w[31:20]);
        compare_field("block", block, w[19:16]);
        compare_field("keyon", keyon, w[15:12]);
        compare_field("con", con, w[11:8]);
        compare_field("fb", fb, w[7:4]);
    endtask

    task automatic scan_zero_cycle();
        for (int i = 0; i < SLOTS; i++) begin
            find_slot(group_t'(i / 6), sub_t'(i % 6));
            check_outputs('0);
            compare_field("zero", zero, i == 0);  // only slot (0,0)
            compare_field("flag_a", flag_a, 0);
            compare_field("flag_b", flag_b, 0);
            compare_field("irq", irq, 0);
            compare_field("wr_ready", wr_ready, 1);
        end
    endtask

    // overflow due between 256 - v and 257 - v slot cycles after the load
    task automatic time_timer_a(input byte_t v);
        time t_lo;
        time t_hi;
        t_lo = last_write + time'((256 - int'(v)) * SLOT_CLKS * CLK_NS);
        t_hi = last_write + time'((257 - int'(v)) * SLOT_CLKS * CLK_NS);
        while (!flag_a) begin
            @(posedge clk);
            #1;
        end
        if ($time < t_lo || $time > t_hi) begin
            $display("flag_a rose at %0d ns, outside the window %0d ns to %0d ns",
                     $time, t_lo, t_hi);
            errors++;
        end
        compare_field("irq", irq, 1);
    endtask

    task automatic watch_quiet(input byte_t n);
        logic seen;
        seen = 1'b0;
        for (int k = 0; k < int'(n) * SLOT_CLKS; k++) begin
            @(posedge clk);
            #1;
            if (!seen && (flag_b !== 1'b0 || irq !== 1'b0)) begin
                compare_field("flag_b", flag_b, 0);
                compare_field("irq", irq, 0);
                seen = 1'b1;  // one report is enough
            end
        end
    endtask

    task automatic check_flags(input logic [2:0] exp);
        @(posedge clk);  // timer control lands a clock after the write
        @(posedge clk);
        #1;
        compare_field("flag_a", flag_a, exp[2]);
        compare_field("flag_b", flag_b, exp[1]);
        compare_field("irq", irq, exp[0]);
    endtask

    initial begin
        logic [79:0] w;
        rst      = 1'b1;
        cen      = 1'b1;
        wr_valid = 1'b0;
        addr     = 1'b0;
        din      = '0;
        for (int k = 0; k < MAX_LINES; k++) begin
            golden[k] = '0;
        end
        $readmemh("bench/fm_golden.txt", golden);
        while (n_lines < MAX_LINES && golden[n_lines][79:76] != 4'h0) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            $display("golden file is empty or could not be read");
            errors++;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_lines; i++) begin
            w = golden[i];
            case (w[79:76])
                4'h1: host_write(w[72], w[7:0], w[68]);
                4'h2: begin
                    wait_ready();
                    find_slot(w[73:72], w[70:68]);
                    check_outputs(w);
                end
                4'h3: time_timer_a(w[7:0]);
                4'h4: watch_quiet(w[7:0]);
                4'h5: check_flags(w[2:0]);
                4'h6: begin
                    wait_ready();
                    scan_zero_cycle();
                end
                default: begin
                    $display("unknown command %0h in golden entry %0d", w[79:76], i);
                    errors++;
                end
            endcase
        end
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // run limit scales with the length of the golden sequence
    initial begin
        wait (rst === 1'b0);
        repeat (n_lines * 200) @(posedge clk);
        $display("timeout, golden sequence not finished after %0d clocks", n_lines * 200);
        $display("Something failed");
        $finish;
    end

endmodule

// File: bench/fm_golden.txt
// one 80-bit hex word per line, underscores only split fields
// cmd 2: cmd group sub mul ar dr rr sl tl en_sus ks fnum block keyon con fb pad
// other: cmd a b zeros arg; 1 write a=addr pin b=busy arg=din, 3 timer A arg=value
// 4 quiet arg=slot cycles, 5 flags arg={flag_a,flag_b,irq}, 6 zero cycle, 0 end
6_0_0_00000_00000_00000_00
// operator slot (1,2) through all four bases
1_0_0_00000_00000_00000_2A
1_1_1_00000_00000_00000_3B
1_0_0_00000_00000_00000_4A
1_1_1_00000_00000_00000_2D
1_0_0_00000_00000_00000_6A
1_1_1_00000_00000_00000_C7
1_0_0_00000_00000_00000_8A
1_1_1_00000_00000_00000_94
// subslot 6 is not a slot
1_0_0_00000_00000_00000_2E
1_1_0_00000_00000_00000_FF
// channel 4 on slots (1,1) and (1,4)
1_0_0_00000_00000_00000_A4
1_1_0_00000_00000_00000_5C
1_0_0_00000_00000_00000_B4
1_1_1_00000_00000_00000_2E
1_0_0_00000_00000_00000_C4
1_1_1_00000_00000_00000_0B
2_1_2_B_C_7_4_9_2D_1_1_000_0_0_0_0_0
2_1_3_0_0_0_0_0_00_0_0_000_0_0_0_0_0
2_1_1_0_0_0_0_0_00_0_0_25C_3_1_1_5_0
2_1_4_0_0_0_0_0_00_0_0_25C_3_1_1_5_0
// timer A from FC, then timer B with its flag masked
1_0_0_00000_00000_00000_02
1_1_0_00000_00000_00000_FC
1_0_0_00000_00000_00000_04
1_1_0_00000_00000_00000_01
3_0_0_00000_00000_00000_FC
5_0_0_00000_00000_00000_05
1_0_0_00000_00000_00000_03
1_1_0_00000_00000_00000_FF
1_0_0_00000_00000_00000_04
1_1_0_00000_00000_00000_22
1_1_0_00000_00000_00000_80
5_0_0_00000_00000_00000_00
4_0_0_00000_00000_00000_12
0_0_0_00000_00000_00000_00

// File: all.f
hdl/fm_pkg.sv
hdl/fm_ifs.sv
hdl/fm_slot_seq.sv
hdl/fm_mmr.sv
hdl/fm_timers.sv
hdl/fm_op_regs.sv
hdl/fm_ch_regs.sv
hdl/fm_regs_top.sv
bench/fm_properties.sv
bench/fm_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fm_tb
FLIST     = all.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf $(OBJDIR)
